// File: logic/intr_defines.svh
// sizing macros for the interrupt controller, included by the packages and the RTL that loops on levels.
`ifndef INTR_DEFINES_SVH
`define INTR_DEFINES_SVH

// number of interrupt request levels handled by the slice.
`define INTR_LEVELS 16

// width of the cpu register-select code.
// room for eight codes, three of them reserved.
`define REG_SEL_W 3

`endif

// File: logic/intr_pkg.sv
// interrupt vector and level types shared by the controller blocks and the testbench.
`default_nettype none

`include "intr_defines.svh"

package intr_pkg;

  // one bit per level; used for requests, pending, mask and write data.
  typedef logic [`INTR_LEVELS-1:0] irq_vec_t;

  // encoded level number, 0 is the lowest priority.
  typedef logic [$clog2(`INTR_LEVELS)-1:0] irq_level_t;

endpackage : intr_pkg

`default_nettype wire

// File: logic/reg_pkg.sv
// register-select codes for cpu writes into the interrupt controller, decoded per block.
`default_nettype none

`include "intr_defines.svh"

package reg_pkg;

  // codes 5 to 7 are reserved and write nothing.
  typedef enum logic [`REG_SEL_W-1:0] {
    SEL_NONE      = 0,  // idle bus, no register touched.
    SEL_MASK_LOAD = 1,  // mask <= wdata.
    SEL_MASK_SET  = 2,  // mask |= wdata.
    SEL_MASK_CLR  = 3,  // mask &= ~wdata.
    SEL_PEND_CLR  = 4   // pending &= ~wdata, request still wins.
  } reg_sel_e;

endpackage : reg_pkg

`default_nettype wire

// File: logic/irq_reg_if.sv
// cpu register write bundle; the top level drives it and the mask and pending blocks decode it.
`timescale 1ns/10ps
`default_nettype none

interface irq_reg_if (
  input logic clk               // write timing reference, same net as mclk.
);

  reg_pkg::reg_sel_e  sel;      // register-select code.
  logic               wr;       // one-cycle write strobe.
  intr_pkg::irq_vec_t wdata;    // write data, one bit per level.

  modport host   (input clk, output sel, output wr, output wdata);  // cpu side.
  modport target (input clk, input sel, input wr, input wdata);     // decoding blocks.

  // a strobe with an unknown code would hit an undefined register.
  a_sel_known : assert property (@(posedge clk) wr |-> !$isunknown(sel))
    else $error("irq_reg_if: write strobe with unknown select code.");

endinterface : irq_reg_if

`default_nettype wire

// File: logic/irq_pending_latch.sv
// sticky pending bits per interrupt level; requests set them, a cpu SEL_PEND_CLR write clears them.
`timescale 1ns/10ps
`default_nettype none

module irq_pending_latch (
  input  logic               mclk,     // system clock.
  input  logic               arst_n,   // async reset, active low.
  input  intr_pkg::irq_vec_t irq_req,  // request levels, sampled each edge.
  irq_reg_if.target          reg_if,   // cpu write port.
  output intr_pkg::irq_vec_t pending   // latched requests.
);

  logic               pend_clr_hit;  // this write targets the pending register.
  intr_pkg::irq_vec_t clr_bits;      // bits asked to clear this cycle.
  intr_pkg::irq_vec_t pending_nxt;   // next pending state.

  // only SEL_PEND_CLR is decoded here; mask codes belong to irq_mask_reg.
  assign pend_clr_hit = reg_if.wr && (reg_if.sel == reg_pkg::SEL_PEND_CLR);
  assign clr_bits     = pend_clr_hit ? reg_if.wdata : '0;  // no strobe, no clear.

  // clear first, then or in the requests so a live request wins.
  assign pending_nxt  = (pending & ~clr_bits) | irq_req;

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;             // nothing pending out of reset.
    end else begin
      pending <= pending_nxt;    // level sampled, held until cleared.
    end
  end

  // a request seen at an edge must read pending afterwards, even under a clear.
  a_req_sets_pending : assert property (
    @(posedge mclk) disable iff (!arst_n)
    (irq_req != '0) |=> ((pending & $past(irq_req)) == $past(irq_req))
  ) else $error("irq_pending_latch: request did not set its pending bit.");

endmodule : irq_pending_latch

`default_nettype wire

// File: logic/irq_mask_reg.sv
// cpu-written interrupt mask register with load, bit-set and bit-clear decode; feeds the selector.
`timescale 1ns/10ps
`default_nettype none

module irq_mask_reg (
  input  logic               mclk,     // system clock.
  input  logic               arst_n,   // active-low async reset.
  irq_reg_if.target          reg_if,   // cpu write port.
  output intr_pkg::irq_vec_t mask      // 1 = level enabled.
);

  intr_pkg::irq_vec_t mask_nxt;        // next mask value.

  // each strobed write picks one mask operation by its select code.
  always_comb begin
    mask_nxt = mask;                                 // hold by default.
    if (reg_if.wr) begin
      case (reg_if.sel)
        reg_pkg::SEL_MASK_LOAD: mask_nxt = reg_if.wdata;           // full load.
        reg_pkg::SEL_MASK_SET:  mask_nxt = mask | reg_if.wdata;    // enable ones.
        reg_pkg::SEL_MASK_CLR:  mask_nxt = mask & ~reg_if.wdata;   // disable ones.
        default:                mask_nxt = mask;  // none, pend clear, reserved.
      endcase
    end
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      mask <= '0;                // all levels blocked after reset.
    end else begin
      mask <= mask_nxt;
    end
  end

  // a load replaces every bit of the old mask.
  a_load_lands : assert property (
    @(posedge mclk) disable iff (!arst_n)
    (reg_if.wr && (reg_if.sel == reg_pkg::SEL_MASK_LOAD)) |=> (mask == $past(reg_if.wdata))
  ) else $error("irq_mask_reg: mask load did not take the written data.");

endmodule : irq_mask_reg

`default_nettype wire

// File: logic/irq_priority_select.sv
// picks the highest-numbered pending and enabled level and registers it with a valid flag.
`timescale 1ns/10ps
`default_nettype none

`include "intr_defines.svh"

module irq_priority_select (
  input  logic                 mclk,       // system clock.
  input  logic                 arst_n,     // async reset, active low.
  input  intr_pkg::irq_vec_t   pending,    // latched requests.
  input  intr_pkg::irq_vec_t   mask,       // enabled levels.
  output logic                 int_valid,  // some level is active.
  output intr_pkg::irq_level_t int_level   // highest active level, 0 when idle.
);

  intr_pkg::irq_vec_t   active;    // pending and enabled.
  logic                 hi_found;  // any active bit.
  intr_pkg::irq_level_t hi_level;  // index of top active bit.

  assign active = pending & mask;

  // scan upward so the last hit is the highest level.
  always_comb begin
    hi_found = 1'b0;
    hi_level = '0;                 // stays zero when nothing is active.
    for (int i = 0; i < `INTR_LEVELS; i++) begin
      if (active[i]) begin
        hi_found = 1'b1;
        hi_level = intr_pkg::irq_level_t'(i);
      end
    end
  end

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      int_valid <= 1'b0;
      int_level <= '0;
    end else begin
      int_valid <= hi_found;     // one cycle behind pending and mask.
      int_level <= hi_level;
    end
  end

  // idle result must present level zero.
  a_idle_level_zero : assert property (
    @(posedge mclk) disable iff (!arst_n)
    !int_valid |-> (int_level == '0)
  ) else $error("irq_priority_select: level nonzero while not valid.");

  // the reported level was pending and enabled on the cycle before.
  a_level_was_active : assert property (
    @(posedge mclk) disable iff (!arst_n)
    int_valid |-> ((($past(pending & mask)) >> int_level) & intr_pkg::irq_vec_t'(1)) != '0
  ) else $error("irq_priority_select: reported level was not pending and enabled.");

endmodule : irq_priority_select

`default_nettype wire

// File: logic/intr_cntlr_top.sv
// interrupt controller top level; plain cpu ports in, pending latch, mask register and selector inside.
`timescale 1ns/10ps
`default_nettype none

module intr_cntlr_top (
  input  logic                 mclk,       // system clock.
  input  logic                 arst_n,     // async reset, active low.
  input  intr_pkg::irq_vec_t   irq_req,    // external request levels.
  input  reg_pkg::reg_sel_e    reg_sel,    // cpu register select.
  input  logic                 reg_wr,     // cpu write strobe.
  input  intr_pkg::irq_vec_t   reg_wdata,  // cpu write data.
  output intr_pkg::irq_vec_t   pic_mask,   // current mask.
  output intr_pkg::irq_vec_t   pending,    // current pending bits.
  output logic                 int_valid,  // interrupt to the cpu.
  output intr_pkg::irq_level_t int_level   // its level.
);

  // cpu write bundle, driven here in the host role.
  irq_reg_if u_reg_if (
    .clk (mclk)
  );

  assign u_reg_if.sel   = reg_sel;
  assign u_reg_if.wr    = reg_wr;
  assign u_reg_if.wdata = reg_wdata;

  // requests into sticky pending bits.
  irq_pending_latch u_pending_latch (
    .mclk    (mclk),
    .arst_n  (arst_n),
    .irq_req (irq_req),
    .reg_if  (u_reg_if.target),
    .pending (pending)
  );

  // cpu mask, one bit per level.
  irq_mask_reg u_mask_reg (
    .mclk   (mclk),
    .arst_n (arst_n),
    .reg_if (u_reg_if.target),
    .mask   (pic_mask)
  );

  // registered highest-level pick.
  irq_priority_select u_priority_select (
    .mclk      (mclk),
    .arst_n    (arst_n),
    .pending   (pending),
    .mask      (pic_mask),
    .int_valid (int_valid),
    .int_level (int_level)
  );

endmodule : intr_cntlr_top

`default_nettype wire

// File: sim/tb_intr_cntlr.sv
// testbench for intr_cntlr_top; runs a directed table, then LCG-driven rows checked against a model.
`timescale 1ns/10ps
`default_nettype none

`include "intr_defines.svh"

module tb_intr_cntlr;

  localparam int CLK_PERIOD  = 10;   // ns.
  localparam int RST_CYCLES  = 2;
  localparam int N_DIR       = 17;   // rows in the directed table.
  localparam int N_RAND      = 200;  // rows from the generator.
  localparam int TIMEOUT_NS  = (N_DIR + N_RAND) * 4 * CLK_PERIOD + (RST_CYCLES + 1) * CLK_PERIOD;

  // one directed step: inputs to apply and outputs expected two cycles later.
  typedef struct packed {
    intr_pkg::irq_vec_t   req;
    reg_pkg::reg_sel_e    sel;
    logic                 wr;
    intr_pkg::irq_vec_t   wdata;
    intr_pkg::irq_vec_t   exp_mask;
    intr_pkg::irq_vec_t   exp_pend;
    logic                 exp_valid;
    intr_pkg::irq_level_t exp_level;
  } row_t;

  logic                 mclk;
  logic                 arst_n;
  intr_pkg::irq_vec_t   irq_req;
  reg_pkg::reg_sel_e    reg_sel;
  logic                 reg_wr;
  intr_pkg::irq_vec_t   reg_wdata;
  intr_pkg::irq_vec_t   pic_mask;
  intr_pkg::irq_vec_t   pending;
  logic                 int_valid;
  intr_pkg::irq_level_t int_level;

  row_t                 rows[$];       // directed table.
  string                row_names[$];  // names, same order.
  intr_pkg::irq_vec_t   m_mask;        // model state, updated at each edge.
  intr_pkg::irq_vec_t   m_pend;
  logic                 m_valid;
  intr_pkg::irq_level_t m_level;
  logic [31:0]          seed;          // LCG state.

  intr_cntlr_top DUT (
    .mclk      (mclk),
    .arst_n    (arst_n),
    .irq_req   (irq_req),
    .reg_sel   (reg_sel),
    .reg_wr    (reg_wr),
    .reg_wdata (reg_wdata),
    .pic_mask  (pic_mask),
    .pending   (pending),
    .int_valid (int_valid),
    .int_level (int_level)
  );

  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;  // 10 ns period.
  end

  // plain LCG, numerical recipes constants.
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // highest set bit, searched from the top down.
  function automatic intr_pkg::irq_level_t top_level(input intr_pkg::irq_vec_t act);
    for (int i = `INTR_LEVELS - 1; i >= 0; i--) begin
      if (act[i]) return intr_pkg::irq_level_t'(i);
    end
    return '0;                                   // nothing active.
  endfunction

  // mask after one edge, from the select code rules.
  function automatic intr_pkg::irq_vec_t next_mask(input intr_pkg::irq_vec_t cur,
                                                   input reg_pkg::reg_sel_e sel,
                                                   input logic wr,
                                                   input intr_pkg::irq_vec_t wdata);
    if (!wr) return cur;                          // no strobe, no write.
    case (sel)
      reg_pkg::SEL_MASK_LOAD: return wdata;
      reg_pkg::SEL_MASK_SET:  return cur | wdata;
      reg_pkg::SEL_MASK_CLR:  return cur & ~wdata;
      default:                return cur;         // other codes leave the mask alone.
    endcase
  endfunction

  // advance the model by one rising edge with the inputs now on the pins.
  task automatic step_model();
    intr_pkg::irq_vec_t act;
    act     = m_pend & m_mask;                    // selector sees the old state.
    m_valid = (act != '0);
    m_level = top_level(act);
    if (reg_wr && (reg_sel == reg_pkg::SEL_PEND_CLR)) begin
      m_pend = (m_pend & ~reg_wdata) | irq_req;   // request beats the clear.
    end else begin
      m_pend = m_pend | irq_req;
    end
    m_mask  = next_mask(m_mask, reg_sel, reg_wr, reg_wdata);
  endtask

  // wait for an edge, update the model, move to the drive point.
  task automatic tick();
    @(posedge mclk);
    step_model();
    #1;
  endtask

  task automatic stop_with_fail();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on the first error.");
  endtask

  task automatic compare_vec(input string name, input string what,
                             input intr_pkg::irq_vec_t exp, input intr_pkg::irq_vec_t act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %h, actual %h", name, what, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic compare_flag(input string name, input string what,
                              input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %b, actual %b", name, what, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic compare_level(input string name, input string what,
                               input intr_pkg::irq_level_t exp, input intr_pkg::irq_level_t act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %0d, actual %0d", name, what, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic check_outputs(input string name, input intr_pkg::irq_vec_t e_mask,
                               input intr_pkg::irq_vec_t e_pend, input logic e_valid,
                               input intr_pkg::irq_level_t e_level);
    compare_vec(name, "pic_mask", e_mask, pic_mask);
    compare_vec(name, "pending", e_pend, pending);
    compare_flag(name, "int_valid", e_valid, int_valid);
    compare_level(name, "int_level", e_level, int_level);
  endtask

  // one row takes two cycles, strobe high in the first only, request held in both.
  task automatic apply_row(input intr_pkg::irq_vec_t req, input reg_pkg::reg_sel_e sel,
                           input logic wr, input intr_pkg::irq_vec_t wdata);
    irq_req   = req;
    reg_sel   = sel;
    reg_wr    = wr;
    reg_wdata = wdata;
    tick();
    reg_wr    = 1'b0;                             // one-cycle strobe.
    reg_sel   = reg_pkg::SEL_NONE;
    tick();
  endtask

  task automatic add_row(input string name, input intr_pkg::irq_vec_t req,
                         input reg_pkg::reg_sel_e sel, input logic wr,
                         input intr_pkg::irq_vec_t wdata, input intr_pkg::irq_vec_t e_mask,
                         input intr_pkg::irq_vec_t e_pend, input logic e_valid,
                         input intr_pkg::irq_level_t e_level);
    rows.push_back('{req, sel, wr, wdata, e_mask, e_pend, e_valid, e_level});
    row_names.push_back(name);
  endtask

  // state carries over from row to row; mask and pending listed after each.
  task automatic build_table();
    add_row("reset_state", 16'h0000, reg_pkg::SEL_NONE, 1'b0, 16'h0000,
            16'h0000, 16'h0000, 1'b0, 4'd0);
    add_row("mask_load", 16'h0000, reg_pkg::SEL_MASK_LOAD, 1'b1, 16'h00f0,
            16'h00f0, 16'h0000, 1'b0, 4'd0);
    add_row("mask_set", 16'h0000, reg_pkg::SEL_MASK_SET, 1'b1, 16'h8001,
            16'h80f1, 16'h0000, 1'b0, 4'd0);
    add_row("mask_clr", 16'h0000, reg_pkg::SEL_MASK_CLR, 1'b1, 16'h0030,
            16'h80c1, 16'h0000, 1'b0, 4'd0);
    add_row("reserved_5", 16'h0000, reg_pkg::reg_sel_e'(3'd5), 1'b1, 16'hffff,
            16'h80c1, 16'h0000, 1'b0, 4'd0);
    add_row("reserved_7", 16'h0000, reg_pkg::reg_sel_e'(3'd7), 1'b1, 16'hffff,
            16'h80c1, 16'h0000, 1'b0, 4'd0);
    add_row("none_strobed", 16'h0000, reg_pkg::SEL_NONE, 1'b1, 16'hffff,
            16'h80c1, 16'h0000, 1'b0, 4'd0);
    add_row("load_no_strobe", 16'h0000, reg_pkg::SEL_MASK_LOAD, 1'b0, 16'hffff,
            16'h80c1, 16'h0000, 1'b0, 4'd0);
    add_row("req_masked", 16'h0002, reg_pkg::SEL_NONE, 1'b0, 16'h0000,
            16'h80c1, 16'h0002, 1'b0, 4'd0);
    add_row("req_enabled", 16'h0040, reg_pkg::SEL_NONE, 1'b0, 16'h0000,
            16'h80c1, 16'h0042, 1'b1, 4'd6);
    add_row("req_dropped", 16'h0000, reg_pkg::SEL_NONE, 1'b0, 16'h0000,
            16'h80c1, 16'h0042, 1'b1, 4'd6);
    add_row("req_higher", 16'h8000, reg_pkg::SEL_NONE, 1'b0, 16'h0000,
            16'h80c1, 16'h8042, 1'b1, 4'd15);
    add_row("pend_clr_top", 16'h0000, reg_pkg::SEL_PEND_CLR, 1'b1, 16'h8000,
            16'h80c1, 16'h0042, 1'b1, 4'd6);
    add_row("pend_clr_held", 16'h0080, reg_pkg::SEL_PEND_CLR, 1'b1, 16'h00c2,
            16'h80c1, 16'h0080, 1'b1, 4'd7);
    add_row("mask_blocks_all", 16'h0000, reg_pkg::SEL_MASK_CLR, 1'b1, 16'hffff,
            16'h0000, 16'h0080, 1'b0, 4'd0);
    add_row("level_zero", 16'h0001, reg_pkg::SEL_MASK_LOAD, 1'b1, 16'h0001,
            16'h0001, 16'h0081, 1'b1, 4'd0);
    add_row("pend_clr_all", 16'h0000, reg_pkg::SEL_PEND_CLR, 1'b1, 16'hffff,
            16'h0001, 16'h0000, 1'b0, 4'd0);
  endtask

  initial begin
    intr_pkg::irq_vec_t r_req;
    reg_pkg::reg_sel_e  r_sel;
    logic               r_wr;
    intr_pkg::irq_vec_t r_wdata;
    arst_n    = 1'b0;                             // reset from time zero.
    irq_req   = '0;
    reg_sel   = reg_pkg::SEL_NONE;
    reg_wr    = 1'b0;
    reg_wdata = '0;
    m_mask    = '0;
    m_pend    = '0;
    m_valid   = 1'b0;
    m_level   = '0;
    seed      = 32'h1a2514c9;
    build_table();
    if (rows.size() != N_DIR) begin
      $display("Directed table holds %0d rows where %0d were expected.", rows.size(), N_DIR);
      stop_with_fail();
    end
    repeat (RST_CYCLES) @(posedge mclk);
    #1;
    arst_n = 1'b1;                                // release at the drive point.
    check_outputs("after_reset", '0, '0, 1'b0, '0);
    foreach (rows[i]) begin
      apply_row(rows[i].req, rows[i].sel, rows[i].wr, rows[i].wdata);
      check_outputs(row_names[i], rows[i].exp_mask, rows[i].exp_pend,
                    rows[i].exp_valid, rows[i].exp_level);
    end
    for (int n = 0; n < N_RAND; n++) begin
      seed    = next_rand(seed);
      r_req   = seed[31:16] & seed[15:0];         // sparse requests.
      seed    = next_rand(seed);
      r_req   = r_req & seed[23:8];
      seed    = next_rand(seed);
      r_sel   = reg_pkg::reg_sel_e'(seed[30:28]);  // reserved codes included.
      r_wr    = seed[27];
      seed    = next_rand(seed);
      r_wdata = seed[31:16];
      apply_row(r_req, r_sel, r_wr, r_wdata);
      check_outputs($sformatf("random_%0d", n), m_mask, m_pend, m_valid, m_level);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  // bounds the run at twice the expected row time.
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns.", TIMEOUT_NS);
    stop_with_fail();
  end

endmodule : tb_intr_cntlr

`default_nettype wire

// File: sim.f
+incdir+logic
logic/intr_pkg.sv
logic/reg_pkg.sv
logic/irq_reg_if.sv
logic/irq_pending_latch.sv
logic/irq_mask_reg.sv
logic/irq_priority_select.sv
logic/intr_cntlr_top.sv
sim/tb_intr_cntlr.sv

// File: Makefile
# Verilator lint, build and run for the interrupt controller testbench.
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_intr_cntlr
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/intr_defines.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "sim: failure reported, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "sim: run ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
